//--- tb.f
design/transform_pkg.sv
design/transform_row_counter.sv
design/transform_fsm.sv
design/transform_dequant.sv
design/transform_butterfly.sv
design/transform_block_regs.sv
design/transform_top.sv
verif/transform_asserts.sv
verif/transform_tb.sv

//--- Bender.yml
package:
  name: transform

sources:
  - design/transform_pkg.sv
  - design/transform_row_counter.sv
  - design/transform_fsm.sv
  - design/transform_dequant.sv
  - design/transform_butterfly.sv
  - design/transform_block_regs.sv
  - design/transform_top.sv
  - target: simulation
    files:
      - verif/transform_asserts.sv
      - verif/transform_tb.sv

//--- verif/transform_tb.sv
/*
 * Testbench for the H.264 luma 4x4 inverse transform. Applies a
 * table of blocks and checks residuals and valid latency against
 * a reference model of dequant, both passes and rounding.
 */
`timescale 1ns/1ps
`default_nettype none

module transform_tb;
	import transform_pkg::*;

	localparam int         CLK_PERIOD      = 40;
	localparam int         RESET_CYCLES    = 16;
	localparam int         NUM_ENTRIES     = 16;
	localparam int         WATCHDOG_CYCLES = NUM_ENTRIES * 40 + RESET_CYCLES;
	localparam logic [1:0] MODE_DC         = 2'd0;
	localparam logic [1:0] MODE_RANDOM     = 2'd1;
	localparam logic [1:0] MODE_ALL        = 2'd2;

	typedef struct packed {
		qp_t          qp;
		total_coeff_t total_coeff;
		logic [31:0]  stall;
		logic [1:0]   mode;
		coeff_t       value;
		logic         busy_start;
	} entry_t;

	logic         clk;
	logic         rst_n;
	logic         ena;
	logic         start;
	qp_t          qp;
	total_coeff_t total_coeff;
	coeff_t       coeff     [BLK_COEFFS];
	residual_t    residual  [BLK_COEFFS];
	logic         valid;
	entry_t       stim      [NUM_ENTRIES];
	coeff_t       drv_coeff [BLK_COEFFS];
	residual_t    exp_res   [BLK_COEFFS];
	logic [31:0]  rng;

	transform_top transform_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.ena         (ena),
		.start       (start),
		.qp          (qp),
		.total_coeff (total_coeff),
		.coeff       (coeff),
		.residual    (residual),
		.valid       (valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_residual(input int idx, input residual_t got, input residual_t exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch residual[%0d] got 0x%h expected 0x%h", idx, got, exp));
		end
	endtask

	task automatic check_valid_latency(input int got, input int exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch valid latency got 0x%h expected 0x%h", got, exp));
		end
	endtask

	task automatic check_block_residuals();
		for (int i = 0; i < BLK_COEFFS; i++) begin
			check_residual(i, residual[i], exp_res[i]);
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Uniform in -64..64
	function automatic coeff_t random_coeff();
		rng = xorshift32(rng);
		return coeff_t'(int'(rng % 32'd129) - 64);
	endfunction

	//------------------------------------------------------------
	// Reference model
	//------------------------------------------------------------
	function automatic int level_scale(input int pos, input int m);
		bit row_odd;
		bit col_odd;
		row_odd = (pos / BLK_SIZE) % 2;
		col_odd = (pos % BLK_SIZE) % 2;
		if (!row_odd && !col_odd) begin
			return LEVEL_SCALE_EE[m];
		end else if (row_odd && col_odd) begin
			return LEVEL_SCALE_OO[m];
		end
		return LEVEL_SCALE_MIX[m];
	endfunction

	task automatic inverse_1d(inout sample_t s0, inout sample_t s1, inout sample_t s2,
		inout sample_t s3);
		int even_sum;
		int even_diff;
		int odd_a;
		int odd_b;
		even_sum  = int'(s0) + int'(s2);
		even_diff = int'(s0) - int'(s2);
		odd_a     = (int'(s1) >>> 1) - int'(s3);
		odd_b     = int'(s1) + (int'(s3) >>> 1);
		s0 = sample_t'(even_sum + odd_b);
		s1 = sample_t'(even_diff + odd_a);
		s2 = sample_t'(even_diff - odd_a);
		s3 = sample_t'(even_sum - odd_b);
	endtask

	task automatic compute_expected(input qp_t q, input total_coeff_t tc);
		int      pos;
		int      shifted;
		sample_t work [BLK_COEFFS];
		sample_t rounded;
		for (int i = 0; i < BLK_COEFFS; i++) begin
			pos       = ZIGZAG_TO_RASTER[i];
			work[pos] = sample_t'((int'(drv_coeff[i]) * level_scale(pos, q % 6)) << (q / 6));
		end
		for (int r = 0; r < BLK_SIZE; r++) begin
			inverse_1d(work[4 * r], work[4 * r + 1], work[4 * r + 2], work[4 * r + 3]);
		end
		for (int c = 0; c < BLK_SIZE; c++) begin
			inverse_1d(work[c], work[c + 4], work[c + 8], work[c + 12]);
		end
		for (int i = 0; i < BLK_COEFFS; i++) begin
			rounded    = sample_t'(int'(work[i]) + int'(ROUND_OFFSET));
			shifted    = int'(rounded) >>> ROUND_SHIFT;
			shifted    = (shifted > RESIDUAL_MAX) ? int'(RESIDUAL_MAX) : shifted;
			shifted    = (shifted < RESIDUAL_MIN) ? int'(RESIDUAL_MIN) : shifted;
			// Zero block shortcut
			exp_res[i] = (tc == '0) ? residual_t'(0) : residual_t'(shifted);
		end
	endtask

	//------------------------------------------------------------
	// Stimulus
	//------------------------------------------------------------
	task automatic fill_table();
		// qp, total_coeff, ena low mask per cycle, mode, value, start while busy
		stim[0]  = '{6'd0,  5'd1,  32'h0,   MODE_DC,     12'sd5,     1'b0};
		stim[1]  = '{6'd12, 5'd1,  32'h0,   MODE_DC,     -12'sd7,    1'b0};
		stim[2]  = '{6'd27, 5'd1,  32'h0,   MODE_DC,     12'sd9,     1'b0};
		stim[3]  = '{6'd51, 5'd1,  32'h0,   MODE_DC,     -12'sd2,    1'b0};
		stim[4]  = '{6'd0,  5'd16, 32'h0,   MODE_RANDOM, 12'sd0,     1'b0};
		stim[5]  = '{6'd7,  5'd16, 32'h5,   MODE_RANDOM, 12'sd0,     1'b0};
		stim[6]  = '{6'd20, 5'd16, 32'h1ff, MODE_RANDOM, 12'sd0,     1'b0};
		stim[7]  = '{6'd26, 5'd16, 32'h0,   MODE_RANDOM, 12'sd0,     1'b1};
		stim[8]  = '{6'd33, 5'd16, 32'h0,   MODE_RANDOM, 12'sd0,     1'b0};
		stim[9]  = '{6'd45, 5'd16, 32'h100, MODE_RANDOM, 12'sd0,     1'b0};
		stim[10] = '{6'd51, 5'd16, 32'h0,   MODE_RANDOM, 12'sd0,     1'b0};
		stim[11] = '{6'd0,  5'd1,  32'h0,   MODE_DC,     12'sd2047,  1'b0};
		stim[12] = '{6'd0,  5'd1,  32'h0,   MODE_DC,     -12'sd2047, 1'b0};
		stim[13] = '{6'd10, 5'd0,  32'h0,   MODE_ALL,    12'sd33,    1'b0};
		stim[14] = '{6'd17, 5'd16, 32'h10,  MODE_RANDOM, 12'sd0,     1'b1};
		stim[15] = '{6'd10, 5'd0,  32'h3,   MODE_ALL,    -12'sd5,    1'b0};
	endtask

	task automatic run_block(input entry_t e);
		int cycles;
		int exp_latency;
		bit seen;
		for (int i = 0; i < BLK_COEFFS; i++) begin
			case (e.mode)
				MODE_DC:     drv_coeff[i] = (i == 0) ? e.value : coeff_t'(0);
				MODE_RANDOM: drv_coeff[i] = random_coeff();
				default:     drv_coeff[i] = e.value;
			endcase
		end
		compute_expected(e.qp, e.total_coeff);
		exp_latency = ((e.total_coeff == '0) ? 2 : 10) + $countones(e.stall);
		@(posedge clk);
		ena         <= 1'b1;
		start       <= 1'b1;
		qp          <= e.qp;
		total_coeff <= e.total_coeff;
		for (int i = 0; i < BLK_COEFFS; i++) begin
			coeff[i] <= drv_coeff[i];
		end
		// Start edge, inputs are free from here on
		@(posedge clk);
		start       <= 1'b0;
		ena         <= ~e.stall[0];
		qp          <= ~e.qp;
		total_coeff <= ~e.total_coeff;
		for (int i = 0; i < BLK_COEFFS; i++) begin
			coeff[i] <= random_coeff();
		end
		cycles = 0;
		seen   = 1'b0;
		while (!seen) begin
			@(negedge clk);
			cycles++;
			if (valid === 1'b1) begin
				seen = 1'b1;
			end else begin
				@(posedge clk);
				ena <= (cycles < 32) ? ~e.stall[cycles] : 1'b1;
				start <= e.busy_start && (cycles == 3);
				if (e.busy_start && cycles == 3) begin
					for (int i = 0; i < BLK_COEFFS; i++) begin
						coeff[i] <= random_coeff();
					end
				end
			end
		end
		check_valid_latency(cycles, exp_latency);
		check_block_residuals();
		@(posedge clk);
		ena <= 1'b1;
		if (e.busy_start) begin
			repeat (12) begin
				@(negedge clk);
				if (valid !== 1'b0) begin
					fail_run("a second valid followed a start given while busy");
				end
			end
			check_block_residuals();
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		ena         = 1'b0;
		start       = 1'b0;
		qp          = '0;
		total_coeff = '0;
		for (int i = 0; i < BLK_COEFFS; i++) begin
			coeff[i]   = '0;
			exp_res[i] = '0;
		end
		rng = 32'h2a43;
		fill_table();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (valid !== 1'b0) begin
			fail_run("valid is high right after reset");
		end
		check_block_residuals();
		for (int n = 0; n < NUM_ENTRIES; n++) begin
			run_block(stim[n]);
		end
		$display("Simulation completed successfully");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		fail_run("timeout, the run did not finish in the expected number of cycles");
	end

endmodule

`default_nettype wire

//--- verif/transform_asserts.sv
/*
 * Control timing checks for the inverse transform, bound to the
 * top level. Covers valid width, reset and start-to-valid latency.
 */
`timescale 1ns/1ps
`default_nettype none

module transform_asserts (
	input logic clk,
	input logic rst_n,
	input logic ena,
	input logic start,
	input logic valid
);
	logic       busy;
	logic [3:0] en_cnt;

	// Block in flight and its enabled cycles so far
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			en_cnt <= '0;
		end else if (!busy) begin
			if (ena && start) begin
				busy   <= 1'b1;
				en_cnt <= '0;
			end
		end else if (valid) begin
			busy <= 1'b0;
		end else if (ena) begin
			en_cnt <= en_cnt + 4'd1;
		end
	end

	valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) valid |=> !valid)
		else $error("valid stayed high for more than one cycle");

	valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !valid)
		else $error("valid high while reset is asserted");

	// Tenth enabled cycle must carry valid
	valid_in_time: assert property (@(posedge clk) disable iff (!rst_n)
		busy && ena && !valid |-> en_cnt < 4'd9)
		else $error("no valid within 10 enabled cycles of start");

endmodule

bind transform_top transform_asserts transform_asserts_inst (
	.clk   (clk),
	.rst_n (rst_n),
	.ena   (ena),
	.start (start),
	.valid (valid)
);

`default_nettype wire

//--- design/transform_top.sv
/*
 * Inverse transform for one H.264 luma 4x4 residual block.
 * Dequantizes zigzag-ordered coefficients, runs row and column
 * passes through one shared butterfly and outputs 9-bit residuals.
 */
`timescale 1ns/1ps
`default_nettype none

module transform_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ena,
	input  logic                        start,
	input  transform_pkg::qp_t          qp,
	input  transform_pkg::total_coeff_t total_coeff,
	input  transform_pkg::coeff_t       coeff    [transform_pkg::BLK_COEFFS],
	output transform_pkg::residual_t    residual [transform_pkg::BLK_COEFFS],
	output logic                        valid
);
	import transform_pkg::*;

	logic      load_block;
	logic      clear_block;
	logic      pass_active;
	logic      col_pass;
	logic      final_write;
	line_idx_t line_idx;
	logic      last_line;
	sample_t   dequant  [BLK_COEFFS];
	sample_t   line_rd  [BLK_SIZE];
	sample_t   line_wr  [BLK_SIZE];

	transform_fsm transform_fsm_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.ena         (ena),
		.start       (start),
		.total_coeff (total_coeff),
		.last_line   (last_line),
		.load_block  (load_block),
		.clear_block (clear_block),
		.pass_active (pass_active),
		.col_pass    (col_pass),
		.final_write (final_write),
		.valid       (valid)
	);

	transform_row_counter transform_row_counter_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.ena         (ena),
		.pass_active (pass_active),
		.line_idx    (line_idx),
		.last_line   (last_line)
	);

	transform_dequant transform_dequant_inst (
		.qp      (qp),
		.coeff   (coeff),
		.dequant (dequant)
	);

	//------------------------------------------------------------
	// Line loop, block regs through butterfly and back
	//------------------------------------------------------------
	transform_butterfly transform_butterfly_inst (
		.line_in  (line_rd),
		.line_out (line_wr)
	);

	transform_block_regs transform_block_regs_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.ena         (ena),
		.load_block  (load_block),
		.clear_block (clear_block),
		.pass_active (pass_active),
		.col_pass    (col_pass),
		.final_write (final_write),
		.line_idx    (line_idx),
		.dequant     (dequant),
		.line_wr     (line_wr),
		.line_rd     (line_rd),
		.residual    (residual)
	);

endmodule

`default_nettype wire

//--- design/transform_block_regs.sv
/*
 * Working 4x4 block in raster order. Presents one row or column
 * to the butterfly and writes the result back in place, with
 * rounding and clipping on the final column pass.
 */
`timescale 1ns/1ps
`default_nettype none

module transform_block_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ena,
	input  logic                     load_block,
	input  logic                     clear_block,
	input  logic                     pass_active,
	input  logic                     col_pass,
	input  logic                     final_write,
	input  transform_pkg::line_idx_t line_idx,
	input  transform_pkg::sample_t   dequant  [transform_pkg::BLK_COEFFS],
	input  transform_pkg::sample_t   line_wr  [transform_pkg::BLK_SIZE],
	output transform_pkg::sample_t   line_rd  [transform_pkg::BLK_SIZE],
	output transform_pkg::residual_t residual [transform_pkg::BLK_COEFFS]
);
	import transform_pkg::*;

	sample_t    blk      [BLK_COEFFS];
	logic [3:0] line_pos [BLK_SIZE];
	sample_t    wr_val   [BLK_SIZE];

	function automatic sample_t round_clip(sample_t v);
		sample_t sum;
		sample_t shifted;
		sum     = v + ROUND_OFFSET;
		shifted = sum >>> ROUND_SHIFT;
		if (shifted > RESIDUAL_MAX) begin
			return RESIDUAL_MAX;
		end
		if (shifted < RESIDUAL_MIN) begin
			return RESIDUAL_MIN;
		end
		return shifted;
	endfunction

	//------------------------------------------------------------
	// Line select, row or column
	//------------------------------------------------------------
	always_comb begin
		for (int k = 0; k < BLK_SIZE; k++) begin
			line_pos[k] = col_pass ? {2'(k), line_idx} : {line_idx, 2'(k)};
			line_rd[k]  = blk[line_pos[k]];
			wr_val[k]   = final_write ? round_clip(line_wr[k]) : line_wr[k];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BLK_COEFFS; i++) begin
				blk[i] <= '0;
			end
		end else if (ena) begin
			if (clear_block) begin
				for (int i = 0; i < BLK_COEFFS; i++) begin
					blk[i] <= '0;
				end
			end else if (load_block) begin
				blk <= dequant;
			end else if (pass_active) begin
				for (int k = 0; k < BLK_SIZE; k++) begin
					blk[line_pos[k]] <= wr_val[k];
				end
			end
		end
	end

	// Entries already clipped after the final pass
	always_comb begin
		for (int i = 0; i < BLK_COEFFS; i++) begin
			residual[i] = blk[i][8:0];
		end
	end

endmodule

`default_nettype wire

//--- design/transform_butterfly.sv
/*
 * H.264 1-D inverse integer transform on four samples.
 * Shared by the row and column passes, purely combinational.
 */
`timescale 1ns/1ps
`default_nettype none

module transform_butterfly (
	input  transform_pkg::sample_t line_in  [transform_pkg::BLK_SIZE],
	output transform_pkg::sample_t line_out [transform_pkg::BLK_SIZE]
);
	import transform_pkg::*;

	sample_t a;
	sample_t b;
	sample_t c;
	sample_t d;
	sample_t e0;
	sample_t e1;
	sample_t e2;
	sample_t e3;

	assign a = line_in[0];
	assign b = line_in[1];
	assign c = line_in[2];
	assign d = line_in[3];

	//------------------------------------------------------------
	// First stage
	//------------------------------------------------------------
	assign e0 = a + c;
	assign e1 = a - c;
	// Odd terms use the half-weight taps
	assign e2 = (b >>> 1) - d;
	assign e3 = b + (d >>> 1);

	//------------------------------------------------------------
	// Second stage
	//------------------------------------------------------------
	assign line_out[0] = e0 + e3;
	assign line_out[1] = e1 + e2;
	assign line_out[2] = e1 - e2;
	assign line_out[3] = e0 - e3;

endmodule

`default_nettype wire

//--- design/transform_dequant.sv
/*
 * Inverse zigzag and dequantization. Places each scan-order
 * coefficient at its raster position and scales it by the flat
 * LevelScale entry for QP mod 6, shifted left by QP div 6.
 */
`timescale 1ns/1ps
`default_nettype none

module transform_dequant (
	input  transform_pkg::qp_t     qp,
	input  transform_pkg::coeff_t  coeff   [transform_pkg::BLK_COEFFS],
	output transform_pkg::sample_t dequant [transform_pkg::BLK_COEFFS]
);
	import transform_pkg::*;

	logic [3:0] qp_div;
	logic [2:0] qp_mod;

	assign qp_div = 4'(qp / 6);
	assign qp_mod = 3'(qp % 6);

	//------------------------------------------------------------
	// One scaler per scan position
	//------------------------------------------------------------
	for (genvar i = 0; i < BLK_COEFFS; i++) begin : g_coeff
		localparam logic [3:0] RASTER  = ZIGZAG_TO_RASTER[i];
		localparam bit         ROW_ODD = RASTER[2];
		localparam bit         COL_ODD = RASTER[0];

		logic [4:0] scale;
		sample_t    scaled;

		// Position class picks the table
		always_comb begin
			if (!ROW_ODD && !COL_ODD) begin
				scale = LEVEL_SCALE_EE[qp_mod];
			end else if (ROW_ODD && COL_ODD) begin
				scale = LEVEL_SCALE_OO[qp_mod];
			end else begin
				scale = LEVEL_SCALE_MIX[qp_mod];
			end
		end

		// 16-bit wrap on both multiply and shift
		assign scaled          = sample_t'(coeff[i]) * sample_t'(scale);
		assign dequant[RASTER] = scaled << qp_div;
	end

endmodule

`default_nettype wire

//--- design/transform_fsm.sv
/*
 * Transform sequencer. Runs dequant, four row passes, four column
 * passes and done, or takes the zero-block shortcut through a clear.
 */
`timescale 1ns/1ps
`default_nettype none

module transform_fsm (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ena,
	input  logic                        start,
	input  transform_pkg::total_coeff_t total_coeff,
	input  logic                        last_line,
	output logic                        load_block,
	output logic                        clear_block,
	output logic                        pass_active,
	output logic                        col_pass,
	output logic                        final_write,
	output logic                        valid
);
	import transform_pkg::*;

	xform_state_t state;
	xform_state_t state_next;
	logic         clr_pending;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_next = (total_coeff == '0) ? DONE : DEQUANT;
				end
			end
			DEQUANT:  state_next = ROW_PASS;
			ROW_PASS: state_next = last_line ? COL_PASS : ROW_PASS;
			COL_PASS: state_next = last_line ? DONE : COL_PASS;
			// Zero block spends one extra cycle here clearing
			DONE:     state_next = clr_pending ? DONE : IDLE;
			default:  state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			clr_pending <= 1'b0;
		end else if (ena) begin
			state <= state_next;
			if (state == IDLE && start) begin
				clr_pending <= (total_coeff == '0);
			end else if (state == DONE) begin
				clr_pending <= 1'b0;
			end
		end
	end

	//------------------------------------------------------------
	// Control decode
	//------------------------------------------------------------
	// Inputs captured on the start edge
	assign load_block  = (state == IDLE) && start && (total_coeff != '0);
	assign clear_block = (state == DONE) && clr_pending;
	assign pass_active = (state == ROW_PASS) || (state == COL_PASS);
	assign col_pass    = (state == COL_PASS);
	assign final_write = (state == COL_PASS);

	// One pulse on the first enabled cycle of a finished block
	assign valid = (state == DONE) && !clr_pending && ena;

endmodule

`default_nettype wire

//--- design/transform_row_counter.sv
/*
 * Line counter for the row and column passes. Steps 0 to 3
 * and wraps, flagging the last line of a pass.
 */
`timescale 1ns/1ps
`default_nettype none

module transform_row_counter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ena,
	input  logic                     pass_active,
	output transform_pkg::line_idx_t line_idx,
	output logic                     last_line
);
	import transform_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_idx <= '0;
		end else if (ena && pass_active) begin
			// Natural 2-bit wrap sets up the next pass at line 0
			line_idx <= line_idx + 2'd1;
		end
	end

	assign last_line = (line_idx == line_idx_t'(BLK_SIZE - 1));

endmodule

`default_nettype wire

//--- design/transform_pkg.sv
/*
 * Shared definitions for the H.264 luma 4x4 inverse transform.
 * Holds the block geometry, value widths, sequencer states, the
 * zigzag scan map and the flat LevelScale tables.
 */
`default_nettype none

package transform_pkg;

	localparam int BLK_SIZE   = 4;
	localparam int BLK_COEFFS = 16;

	typedef logic signed [11:0] coeff_t;
	typedef logic        [5:0]  qp_t;
	typedef logic        [4:0]  total_coeff_t;
	typedef logic signed [15:0] sample_t;
	typedef logic signed [8:0]  residual_t;
	typedef logic        [1:0]  line_idx_t;

	typedef enum logic [2:0] {
		IDLE,
		DEQUANT,
		ROW_PASS,
		COL_PASS,
		DONE
	} xform_state_t;

	// Scan index to raster index
	localparam logic [3:0] ZIGZAG_TO_RASTER [BLK_COEFFS] = '{
		4'd0, 4'd1, 4'd4, 4'd8, 4'd5, 4'd2, 4'd3, 4'd6,
		4'd9, 4'd12, 4'd13, 4'd10, 4'd7, 4'd11, 4'd14, 4'd15
	};

	// LevelScale by QP mod 6, flat weighting
	localparam logic [4:0] LEVEL_SCALE_EE  [6] = '{5'd10, 5'd11, 5'd13, 5'd14, 5'd16, 5'd18};
	localparam logic [4:0] LEVEL_SCALE_OO  [6] = '{5'd16, 5'd18, 5'd20, 5'd23, 5'd25, 5'd29};
	localparam logic [4:0] LEVEL_SCALE_MIX [6] = '{5'd13, 5'd14, 5'd16, 5'd18, 5'd20, 5'd23};

	localparam sample_t ROUND_OFFSET = 16'sd32;
	localparam int      ROUND_SHIFT  = 6;

	localparam sample_t RESIDUAL_MIN = -16'sd256;
	localparam sample_t RESIDUAL_MAX = 16'sd255;

endpackage

`default_nettype wire
